// File: lsu_ctrl.f
+incdir+tests
rtl/lsu_pkg.sv
rtl/lsu_excl_monitor.sv
rtl/lsu_outs_fifo.sv
rtl/lsu_icb_splitter.sv
rtl/lsu_wbck_fmt.sv
rtl/lsu_ctrl.sv
tests/tb_lsu_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -f lsu_ctrl.f --top-module tb_lsu_ctrl \
  -o tb_lsu_ctrl > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_lsu_ctrl > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: tests/tb_lsu_model.svh
/*
  Reference model for the load-store control unit testbench
  - Expected-response entry and in-order queue
  - Reference memory with an address-derived fill pattern
  - Reservation state, byte masks and load formatting
*/
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

typedef struct packed {
  logic        to_dtcm;
  logic        back2agu;
  logic        err;
  logic        excl_ok;
  logic        ld;
  logic [2:0]  itag;
  logic [31:0] addr;
  logic [31:0] raw;
  logic        chk_wdat;
  logic [31:0] wdat;
} exp_t;

exp_t        exp_q[$];
logic [31:0] ref_mem [logic [29:0]];
logic        resv_valid;
logic [31:0] resv_addr;

// Unwritten words read back a pattern built from every word-address bit
function automatic logic [31:0] fill_word(input logic [29:0] widx);
  return {widx[13:0], widx[29:12]} ^ 32'h5a3c_96e1;
endfunction

function automatic logic [31:0] ref_read(input logic [31:0] addr);
  return ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : fill_word(addr[31:2]);
endfunction

function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                  input logic [3:0] mask);
  logic [31:0] word;
  int          i;
  word = ref_read(addr);
  for (i = 0; i < 4; i++) begin
    if (mask[i]) word[8*i +: 8] = data[8*i +: 8];
  end
  ref_mem[addr[31:2]] = word;
endfunction

function automatic logic [3:0] byte_mask(input logic [1:0] size, input logic [1:0] off);
  case (size)
    lsu_pkg::SIZE_BYTE: return 4'b0001 << off;
    lsu_pkg::SIZE_HALF: return 4'b0011 << off;
    default:            return 4'b1111;
  endcase
endfunction

// Byte lane moves down to bit 0, then zero or sign extension by size
function automatic logic [31:0] load_format(input logic [31:0] word, input logic [1:0] off,
                                            input logic [1:0] size, input logic usign);
  logic [31:0] sh;
  sh = word >> (8 * off);
  case (size)
    lsu_pkg::SIZE_BYTE: return usign ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
    lsu_pkg::SIZE_HALF: return usign ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
    default:            return sh;
  endcase
endfunction

`endif

// File: tests/tb_lsu_ctrl.sv
/*
  Testbench for the load-store control unit
  - Clock, reset, random AGU commands and commit strobes
  - DTCM and BIU memory models with random ready, latency and errors
  - In-order checks of write-back and AGU replies against the model
*/
module tb_lsu_ctrl;

  localparam int          OUTS_NUM      = 2;
  localparam int          DTCM_AW       = 16;
  localparam int          NUM_CMDS      = 3000;
  localparam int          TIMEOUT       = 400;
  localparam logic [31:0] DTCM_BASE     = 32'h8000_0000;
  localparam logic [31:0] BIU_BASE      = 32'h8001_0000;
  localparam logic [31:0] DTCM_OFS_MASK = (32'h1 << DTCM_AW) - 1;

  logic               clk;
  logic               i_rst_n;
  logic               i_commit_trap;
  logic               i_commit_mret;
  logic [31:0]        i_dtcm_region_indic;
  logic               o_lsu_active;
  logic               i_agu_cmd_valid;
  logic               o_agu_cmd_ready;
  lsu_pkg::lsu_cmd_t  i_agu_cmd;
  lsu_pkg::lsu_usr_t  i_agu_usr;
  logic               o_agu_rsp_valid;
  logic               i_agu_rsp_ready;
  lsu_pkg::lsu_rsp_t  o_agu_rsp;
  logic               o_wbck_valid;
  logic               i_wbck_ready;
  lsu_pkg::lsu_wbck_t o_wbck;
  logic               o_dtcm_cmd_valid;
  logic               i_dtcm_cmd_ready;
  lsu_pkg::lsu_cmd_t  o_dtcm_cmd;
  logic               i_dtcm_rsp_valid;
  logic               o_dtcm_rsp_ready;
  lsu_pkg::lsu_rsp_t  i_dtcm_rsp;
  logic               o_biu_cmd_valid;
  logic               i_biu_cmd_ready;
  lsu_pkg::lsu_cmd_t  o_biu_cmd;
  logic               i_biu_rsp_valid;
  logic               o_biu_rsp_ready;
  lsu_pkg::lsu_rsp_t  i_biu_rsp;

  `include "tb_lsu_model.svh"

  // Target memory with DTCM offsets mapped back into the DTCM region
  logic [31:0]       tgt_mem [logic [29:0]];
  lsu_pkg::lsu_rsp_t dtcm_q[$];
  int                dtcm_due_q[$];
  lsu_pkg::lsu_rsp_t biu_q[$];
  int                biu_due_q[$];
  int                cyc;
  int                issued;
  int                agu_wait;
  int                rsp_wait;
  logic              cmd_pending;
  logic              cur_to_dtcm;
  logic [31:0]       last_lr_addr;

  lsu_ctrl #(.OUTS_NUM(OUTS_NUM), .DTCM_ADDR_W(DTCM_AW)) lsu_ctrl_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic ok, input string msg);
    assert (ok) else fail_run($sformatf("error at %0t: %s", $time, msg));
  endtask

  ////////////////////
  // Stimulus

  task automatic make_command();
    int          kind;
    logic [1:0]  sz;
    logic [1:0]  off;
    logic [31:0] addr;
    // 0..5 load, 6..8 store, 9 load-reserved, 10..11 store-conditional
    kind = $urandom_range(11);
    sz   = (kind >= 9) ? lsu_pkg::SIZE_WORD : 2'($urandom_range(2));
    off  = 2'($urandom_range(3));
    if (sz == lsu_pkg::SIZE_WORD) off = 2'b00;
    if (sz == lsu_pkg::SIZE_HALF) off[0] = 1'b0;
    if (kind >= 10 && $urandom_range(3) != 0) begin
      addr = last_lr_addr;
    end else begin
      addr = ($urandom_range(1) != 0) ? DTCM_BASE : BIU_BASE;
      addr = addr | {27'h0, 3'($urandom_range(7)), 2'b00} | {30'h0, off};
    end
    if (kind == 9) last_lr_addr = addr;
    cur_to_dtcm        = (addr[31:16] == DTCM_BASE[31:16]);
    i_agu_cmd.addr     = addr;
    i_agu_cmd.read     = (kind <= 5) || (kind == 9);
    i_agu_cmd.wdata    = $urandom;
    i_agu_cmd.wmask    = byte_mask(sz, off);
    i_agu_cmd.excl     = (kind >= 9);
    i_agu_cmd.size     = sz;
    i_agu_usr.back2agu = (kind <= 8) && ($urandom_range(7) == 0);
    i_agu_usr.usign    = 1'($urandom_range(1));
    i_agu_usr.read     = i_agu_cmd.read;
    i_agu_usr.size     = sz;
    i_agu_usr.itag     = 3'(issued);
    i_agu_usr.addr     = addr;
    i_agu_usr.excl     = i_agu_cmd.excl;
  endtask

  task automatic drive_inputs(input logic allow_new);
    @(posedge clk);
    #5;
    cyc++;
    i_commit_trap = 1'b0;
    i_commit_mret = 1'b0;
    if (!cmd_pending && allow_new && $urandom_range(3) != 0) begin
      make_command();
      cmd_pending     = 1'b1;
      i_agu_cmd_valid = 1'b1;
    end else if (!cmd_pending) begin
      // Commit strobes only in idle cycles
      i_agu_cmd_valid = 1'b0;
      i_commit_trap   = ($urandom_range(47) == 0);
      i_commit_mret   = ($urandom_range(47) == 0);
    end
    i_dtcm_cmd_ready = ($urandom_range(3) != 0);
    i_biu_cmd_ready  = ($urandom_range(3) != 0);
    i_wbck_ready     = ($urandom_range(3) != 0);
    i_agu_rsp_ready  = ($urandom_range(3) != 0);
    i_dtcm_rsp_valid = (dtcm_q.size() != 0) && (dtcm_due_q[0] <= cyc);
    i_dtcm_rsp       = i_dtcm_rsp_valid ? dtcm_q[0] : '0;
    i_biu_rsp_valid  = (biu_q.size() != 0) && (biu_due_q[0] <= cyc);
    i_biu_rsp        = i_biu_rsp_valid ? biu_q[0] : '0;
  endtask

  ////////////////////
  // Target models and checks

  task automatic serve_target(input lsu_pkg::lsu_cmd_t c, input logic to_dtcm, input logic err,
                              input logic xok);
    logic [29:0]       k;
    logic [31:0]       word;
    lsu_pkg::lsu_rsp_t r;
    int                i;
    k       = to_dtcm ? {DTCM_BASE[31:16], c.addr[15:2]} : c.addr[31:2];
    word    = tgt_mem.exists(k) ? tgt_mem[k] : fill_word(k);
    r.err   = err;
    r.excl_ok = xok;
    r.rdata = c.read ? word : 32'h0;
    if (!c.read) begin
      for (i = 0; i < 4; i++) begin
        if (c.wmask[i]) word[8*i +: 8] = c.wdata[8*i +: 8];
      end
      tgt_mem[k] = word;
    end
    // Response no earlier than the cycle after acceptance
    if (to_dtcm) begin
      dtcm_q.push_back(r);
      dtcm_due_q.push_back(cyc + 1 + int'($urandom_range(3)));
    end else begin
      biu_q.push_back(r);
      biu_due_q.push_back(cyc + 1 + int'($urandom_range(3)));
    end
  endtask

  task automatic accept_command();
    exp_t              e;
    lsu_pkg::lsu_cmd_t pc;
    logic              sc;
    logic              sc_ok;
    logic              err;
    logic              xok;
    sc    = i_agu_cmd.excl & ~i_agu_cmd.read;
    sc_ok = sc & resv_valid & (resv_addr == i_agu_cmd.addr);
    pc    = i_agu_cmd;
    if (sc && !sc_ok) pc.wmask = 4'h0;
    if (cur_to_dtcm) pc.addr = i_agu_cmd.addr & DTCM_OFS_MASK;
    check((cur_to_dtcm ? o_dtcm_cmd : o_biu_cmd) == pc,
          $sformatf("target command differs for addr %h", i_agu_cmd.addr));
    err = ($urandom_range(15) == 0);
    xok = 1'($urandom_range(1));
    serve_target(cur_to_dtcm ? o_dtcm_cmd : o_biu_cmd, cur_to_dtcm, err, xok);
    e.raw = i_agu_cmd.read ? ref_read(i_agu_cmd.addr) : 32'h0;
    if (!i_agu_cmd.read) ref_write(i_agu_cmd.addr, i_agu_cmd.wdata, pc.wmask);
    if (i_agu_cmd.read && i_agu_cmd.excl) begin
      resv_valid = 1'b1;
      resv_addr  = i_agu_cmd.addr;
    end else if (!i_agu_cmd.read && resv_valid && resv_addr == i_agu_cmd.addr) begin
      resv_valid = 1'b0;
    end
    e.to_dtcm  = cur_to_dtcm;
    e.back2agu = i_agu_usr.back2agu;
    e.err      = err;
    e.excl_ok  = xok;
    e.ld       = i_agu_cmd.read;
    e.itag     = i_agu_usr.itag;
    e.addr     = i_agu_cmd.addr;
    e.chk_wdat = i_agu_cmd.read | sc;
    e.wdat     = sc ? (sc_ok ? 32'h0 : 32'h1)
                    : load_format(e.raw, i_agu_cmd.addr[1:0], i_agu_cmd.size, i_agu_usr.usign);
    exp_q.push_back(e);
  endtask

  task automatic check_response(output logic popped);
    exp_t e;
    popped = 1'b0;
    if (o_wbck_valid || o_agu_rsp_valid) begin
      check(exp_q.size() != 0, "response with nothing outstanding");
      e = exp_q[0];
      if (e.back2agu) begin
        check(o_agu_rsp_valid && !o_wbck_valid, $sformatf("itag %0d not on AGU reply", e.itag));
        check(o_agu_rsp.rdata == e.raw && o_agu_rsp.err == e.err
              && o_agu_rsp.excl_ok == e.excl_ok,
              $sformatf("AGU rdata %h err %b excl_ok %b, expected %h %b %b", o_agu_rsp.rdata,
                        o_agu_rsp.err, o_agu_rsp.excl_ok, e.raw, e.err, e.excl_ok));
        popped = i_agu_rsp_ready;
      end else begin
        check(o_wbck_valid && !o_agu_rsp_valid, $sformatf("itag %0d not on write-back", e.itag));
        check(o_wbck.itag == e.itag && o_wbck.err == e.err && o_wbck.buserr == e.err,
              $sformatf("itag %0d err %b, expected %0d %b", o_wbck.itag, o_wbck.err,
                        e.itag, e.err));
        check((!e.err || o_wbck.badaddr == e.addr) && o_wbck.ld == e.ld && o_wbck.st == !e.ld,
              $sformatf("commit fields wrong for addr %h", e.addr));
        check(!e.chk_wdat || o_wbck.wdat == e.wdat,
              $sformatf("wdat %h, expected %h at addr %h", o_wbck.wdat, e.wdat, e.addr));
        popped = i_wbck_ready;
      end
      if (popped) void'(exp_q.pop_front());
    end
  endtask

  task automatic sample_cycle();
    logic fire;
    logic popped;
    logic tgt_pop;
    logic rdy_exp;
    fire = i_agu_cmd_valid & o_agu_cmd_ready;
    // Both targets ready, room left, and no commands in flight to the other target
    rdy_exp = i_dtcm_cmd_ready & i_biu_cmd_ready & (exp_q.size() < OUTS_NUM)
            & ((exp_q.size() == 0) || (exp_q[0].to_dtcm == cur_to_dtcm));
    check(o_lsu_active == (i_agu_cmd_valid | (exp_q.size() != 0)), "o_lsu_active wrong");
    check(o_agu_cmd_ready == rdy_exp,
          $sformatf("AGU command ready %b, expected %b", o_agu_cmd_ready, rdy_exp));
    check(!o_dtcm_cmd_valid || (cmd_pending && cur_to_dtcm), "DTCM valid for a BIU address");
    check(!o_biu_cmd_valid || (cmd_pending && !cur_to_dtcm), "BIU valid for a DTCM address");
    check(fire == ((o_dtcm_cmd_valid & i_dtcm_cmd_ready) | (o_biu_cmd_valid & i_biu_cmd_ready)),
          "target accept differs from AGU accept");
    check_response(popped);
    tgt_pop = (i_dtcm_rsp_valid & o_dtcm_rsp_ready) | (i_biu_rsp_valid & o_biu_rsp_ready);
    check(popped == tgt_pop, "target response transfer differs from output transfer");
    if (i_dtcm_rsp_valid && o_dtcm_rsp_ready) begin
      void'(dtcm_q.pop_front());
      void'(dtcm_due_q.pop_front());
    end
    if (i_biu_rsp_valid && o_biu_rsp_ready) begin
      void'(biu_q.pop_front());
      void'(biu_due_q.pop_front());
    end
    if (fire) begin
      accept_command();
      cmd_pending = 1'b0;
      agu_wait    = 0;
      issued++;
    end else if (cmd_pending) begin
      agu_wait++;
      if (agu_wait > TIMEOUT) fail_run("timeout waiting for the AGU command to be accepted");
    end
    if (i_commit_trap || i_commit_mret) resv_valid = 1'b0;
    rsp_wait = (popped || exp_q.size() == 0) ? 0 : rsp_wait + 1;
    if (rsp_wait > TIMEOUT) fail_run("timeout waiting for a response from the DUT");
  endtask

  initial begin
    int n;
    void'($urandom(32'h0838_38f0));
    i_rst_n             = 1'b0;
    i_commit_trap       = 1'b0;
    i_commit_mret       = 1'b0;
    i_dtcm_region_indic = DTCM_BASE;
    i_agu_cmd_valid     = 1'b0;
    i_agu_cmd           = '0;
    i_agu_usr           = '0;
    i_agu_rsp_ready     = 1'b0;
    i_wbck_ready        = 1'b0;
    i_dtcm_cmd_ready    = 1'b0;
    i_dtcm_rsp_valid    = 1'b0;
    i_dtcm_rsp          = '0;
    i_biu_cmd_ready     = 1'b0;
    i_biu_rsp_valid     = 1'b0;
    i_biu_rsp           = '0;
    cmd_pending         = 1'b0;
    cur_to_dtcm         = 1'b0;
    resv_valid          = 1'b0;
    resv_addr           = '0;
    last_lr_addr        = DTCM_BASE;
    cyc                 = 0;
    issued              = 0;
    agu_wait            = 0;
    rsp_wait            = 0;
    repeat (10) @(posedge clk);
    #5;
    i_rst_n = 1'b1;
    @(negedge clk);
    check(!o_wbck_valid && !o_agu_rsp_valid && !o_lsu_active, "outputs active after reset");
    check(!o_dtcm_rsp_ready && !o_biu_rsp_ready, "target response ready after reset");
    while (issued < NUM_CMDS) begin
      drive_inputs(1'b1);
      @(negedge clk);
      sample_cycle();
    end
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > TIMEOUT) fail_run("timeout waiting for outstanding responses to drain");
      drive_inputs(1'b0);
      @(negedge clk);
      sample_cycle();
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// File: rtl/lsu_ctrl.sv
/*
  Load-store control unit top level
  - AGU command and response ports, write-back port
  - DTCM and BIU target ports
  - Exclusive monitor, outstanding FIFO, splitter and write-back formatter
*/
module lsu_ctrl #(
  parameter int OUTS_NUM    = 2,
  parameter int DTCM_ADDR_W = 16
) (
  input  logic                           clk,
  input  logic                           i_rst_n,

  input  logic                           i_commit_trap,
  input  logic                           i_commit_mret,
  input  logic [lsu_pkg::ADDR_W-1:0]     i_dtcm_region_indic,
  output logic                           o_lsu_active,

  // AGU command and raw response
  input  logic                           i_agu_cmd_valid,
  output logic                           o_agu_cmd_ready,
  input  lsu_pkg::lsu_cmd_t              i_agu_cmd,
  input  lsu_pkg::lsu_usr_t              i_agu_usr,
  output logic                           o_agu_rsp_valid,
  input  logic                           i_agu_rsp_ready,
  output lsu_pkg::lsu_rsp_t              o_agu_rsp,

  // Register write-back
  output logic                           o_wbck_valid,
  input  logic                           i_wbck_ready,
  output lsu_pkg::lsu_wbck_t             o_wbck,

  // DTCM target
  output logic                           o_dtcm_cmd_valid,
  input  logic                           i_dtcm_cmd_ready,
  output lsu_pkg::lsu_cmd_t              o_dtcm_cmd,
  input  logic                           i_dtcm_rsp_valid,
  output logic                           o_dtcm_rsp_ready,
  input  lsu_pkg::lsu_rsp_t              i_dtcm_rsp,

  // BIU target
  output logic                           o_biu_cmd_valid,
  input  logic                           i_biu_cmd_ready,
  output lsu_pkg::lsu_cmd_t              o_biu_cmd,
  input  logic                           i_biu_rsp_valid,
  output logic                           o_biu_rsp_ready,
  input  lsu_pkg::lsu_rsp_t              i_biu_rsp
);

  logic                        cmd_fire;
  logic                        cmd_to_dtcm;
  logic [lsu_pkg::MASK_W-1:0]  cmd_wmask;
  logic                        scond_true;
  logic                        fifo_full;
  logic                        fifo_valid;
  lsu_pkg::lsu_outs_t          fifo_push_data;
  lsu_pkg::lsu_outs_t          fifo_head;
  logic                        rsp_valid;
  logic                        rsp_ready;
  lsu_pkg::lsu_rsp_t           rsp;

  // Entry recorded for every accepted command
  assign fifo_push_data = '{to_dtcm: cmd_to_dtcm, scond_true: scond_true, usr: i_agu_usr};

  assign o_lsu_active = i_agu_cmd_valid | fifo_valid;

  lsu_excl_monitor excl_monitor_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_fire    (cmd_fire),
    .i_cmd         (i_agu_cmd),
    .i_commit_trap (i_commit_trap),
    .i_commit_mret (i_commit_mret),
    .o_cmd_wmask   (cmd_wmask),
    .o_scond_true  (scond_true)
  );

  lsu_outs_fifo #(
    .OUTS_NUM (OUTS_NUM)
  ) outs_fifo_inst (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_push      (cmd_fire),
    .i_push_data (fifo_push_data),
    .i_pop       (rsp_valid & rsp_ready),
    .o_full      (fifo_full),
    .o_valid     (fifo_valid),
    .o_head      (fifo_head)
  );

  lsu_icb_splitter #(
    .DTCM_ADDR_W (DTCM_ADDR_W)
  ) icb_splitter_inst (
    .i_cmd_valid         (i_agu_cmd_valid),
    .i_cmd               (i_agu_cmd),
    .i_cmd_wmask         (cmd_wmask),
    .i_dtcm_region_indic (i_dtcm_region_indic),
    .i_fifo_full         (fifo_full),
    .i_fifo_valid        (fifo_valid),
    .i_fifo_head         (fifo_head),
    .o_cmd_ready         (o_agu_cmd_ready),
    .o_cmd_fire          (cmd_fire),
    .o_cmd_to_dtcm       (cmd_to_dtcm),
    .o_dtcm_cmd_valid    (o_dtcm_cmd_valid),
    .i_dtcm_cmd_ready    (i_dtcm_cmd_ready),
    .o_dtcm_cmd          (o_dtcm_cmd),
    .i_dtcm_rsp_valid    (i_dtcm_rsp_valid),
    .o_dtcm_rsp_ready    (o_dtcm_rsp_ready),
    .i_dtcm_rsp          (i_dtcm_rsp),
    .o_biu_cmd_valid     (o_biu_cmd_valid),
    .i_biu_cmd_ready     (i_biu_cmd_ready),
    .o_biu_cmd           (o_biu_cmd),
    .i_biu_rsp_valid     (i_biu_rsp_valid),
    .o_biu_rsp_ready     (o_biu_rsp_ready),
    .i_biu_rsp           (i_biu_rsp),
    .i_rsp_ready         (rsp_ready),
    .o_rsp_valid         (rsp_valid),
    .o_rsp               (rsp)
  );

  lsu_wbck_fmt wbck_fmt_inst (
    .i_rsp_valid     (rsp_valid),
    .i_rsp           (rsp),
    .i_head          (fifo_head),
    .i_wbck_ready    (i_wbck_ready),
    .i_agu_rsp_ready (i_agu_rsp_ready),
    .o_rsp_ready     (rsp_ready),
    .o_wbck_valid    (o_wbck_valid),
    .o_wbck          (o_wbck),
    .o_agu_rsp_valid (o_agu_rsp_valid),
    .o_agu_rsp       (o_agu_rsp)
  );

endmodule

// File: rtl/lsu_wbck_fmt.sv
/*
  Response routing and write-back formatting
  - back2agu responses go raw to the AGU
  - Load alignment and sign or zero extension
  - SC result and bus-error commit fields
*/
module lsu_wbck_fmt (
  input  logic                i_rsp_valid,
  input  lsu_pkg::lsu_rsp_t   i_rsp,
  input  lsu_pkg::lsu_outs_t  i_head,
  input  logic                i_wbck_ready,
  input  logic                i_agu_rsp_ready,
  output logic                o_rsp_ready,
  output logic                o_wbck_valid,
  output lsu_pkg::lsu_wbck_t  o_wbck,
  output logic                o_agu_rsp_valid,
  output lsu_pkg::lsu_rsp_t   o_agu_rsp
);

  localparam int XL = lsu_pkg::XLEN;

  lsu_pkg::lsu_usr_t usr;
  logic [XL-1:0]     rdata_algn;
  logic [XL-1:0]     ld_data;
  logic              scond;

  assign usr = i_head.usr;

  ////////////////////
  // Routing

  assign o_wbck_valid    = i_rsp_valid & ~usr.back2agu;
  assign o_agu_rsp_valid = i_rsp_valid & usr.back2agu;
  assign o_rsp_ready     = usr.back2agu ? i_agu_rsp_ready : i_wbck_ready;
  assign o_agu_rsp       = i_rsp;

  ////////////////////
  // Load data

  // Move the addressed byte lane down to bit 0
  assign rdata_algn = i_rsp.rdata >> {usr.addr[1:0], 3'b000};

  always_comb begin
    case (usr.size)
      lsu_pkg::SIZE_BYTE: begin
        ld_data = {{(XL-8){~usr.usign & rdata_algn[7]}}, rdata_algn[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        ld_data = {{(XL-16){~usr.usign & rdata_algn[15]}}, rdata_algn[15:0]};
      end
      default: begin
        ld_data = rdata_algn;
      end
    endcase
  end

  // SC writes 0 on success, 1 on failure
  assign scond = ~usr.read & usr.excl;

  always_comb begin
    o_wbck.wdat    = scond ? (i_head.scond_true ? '0 : XL'(1)) : ld_data;
    o_wbck.itag    = usr.itag;
    o_wbck.err     = i_rsp.err;
    o_wbck.buserr  = i_rsp.err;
    o_wbck.badaddr = usr.addr;
    o_wbck.ld      = usr.read;
    o_wbck.st      = ~usr.read;
  end

endmodule

// File: rtl/lsu_icb_splitter.sv
/*
  ICB splitter between the AGU and the two targets
  - DTCM region decode and issue gating
  - Command fan-out to DTCM or BIU
  - Response select from the target at the FIFO head
*/
module lsu_icb_splitter #(
  parameter int DTCM_ADDR_W = 16
) (
  input  logic                       i_cmd_valid,
  input  lsu_pkg::lsu_cmd_t          i_cmd,
  input  logic [lsu_pkg::MASK_W-1:0] i_cmd_wmask,
  input  logic [lsu_pkg::ADDR_W-1:0] i_dtcm_region_indic,
  input  logic                       i_fifo_full,
  input  logic                       i_fifo_valid,
  input  lsu_pkg::lsu_outs_t         i_fifo_head,
  output logic                       o_cmd_ready,
  output logic                       o_cmd_fire,
  output logic                       o_cmd_to_dtcm,

  output logic                       o_dtcm_cmd_valid,
  input  logic                       i_dtcm_cmd_ready,
  output lsu_pkg::lsu_cmd_t          o_dtcm_cmd,
  input  logic                       i_dtcm_rsp_valid,
  output logic                       o_dtcm_rsp_ready,
  input  lsu_pkg::lsu_rsp_t          i_dtcm_rsp,

  output logic                       o_biu_cmd_valid,
  input  logic                       i_biu_cmd_ready,
  output lsu_pkg::lsu_cmd_t          o_biu_cmd,
  input  logic                       i_biu_rsp_valid,
  output logic                       o_biu_rsp_ready,
  input  lsu_pkg::lsu_rsp_t          i_biu_rsp,

  input  logic                       i_rsp_ready,
  output logic                       o_rsp_valid,
  output lsu_pkg::lsu_rsp_t          o_rsp
);

  localparam int AW = lsu_pkg::ADDR_W;

  logic cmd_diff_target;
  logic issue_ok;
  logic cmd_valid_pos;
  logic rsp_dtcm;
  logic rsp_biu;

  ////////////////////
  // Command side

  assign o_cmd_to_dtcm = (i_cmd.addr[AW-1:DTCM_ADDR_W]
                          == i_dtcm_region_indic[AW-1:DTCM_ADDR_W]);

  // Only one target may have commands in flight at a time
  assign cmd_diff_target = i_fifo_valid & (o_cmd_to_dtcm != i_fifo_head.to_dtcm);
  assign issue_ok        = ~i_fifo_full & ~cmd_diff_target;
  assign cmd_valid_pos   = i_cmd_valid & issue_ok;

  // Ready asks for both targets, keeping the address out of the ready path
  assign o_cmd_ready = issue_ok & i_dtcm_cmd_ready & i_biu_cmd_ready;
  assign o_cmd_fire  = i_cmd_valid & o_cmd_ready;

  assign o_dtcm_cmd_valid = cmd_valid_pos & o_cmd_to_dtcm & i_biu_cmd_ready;
  assign o_biu_cmd_valid  = cmd_valid_pos & ~o_cmd_to_dtcm & i_dtcm_cmd_ready;

  always_comb begin
    o_dtcm_cmd       = i_cmd;
    o_dtcm_cmd.wmask = i_cmd_wmask;
    // DTCM sees offsets within its region only
    o_dtcm_cmd.addr  = '0;
    o_dtcm_cmd.addr[DTCM_ADDR_W-1:0] = i_cmd.addr[DTCM_ADDR_W-1:0];

    o_biu_cmd        = i_cmd;
    o_biu_cmd.wmask  = i_cmd_wmask;
  end

  ////////////////////
  // Response side

  assign rsp_dtcm = i_fifo_valid & i_fifo_head.to_dtcm;
  assign rsp_biu  = i_fifo_valid & ~i_fifo_head.to_dtcm;

  assign o_rsp_valid = (rsp_dtcm & i_dtcm_rsp_valid) | (rsp_biu & i_biu_rsp_valid);

  always_comb begin
    if (rsp_dtcm) begin
      o_rsp = i_dtcm_rsp;
    end else if (rsp_biu) begin
      o_rsp = i_biu_rsp;
    end else begin
      o_rsp = '0;
    end
  end

  assign o_dtcm_rsp_ready = rsp_dtcm & i_rsp_ready;
  assign o_biu_rsp_ready  = rsp_biu & i_rsp_ready;

endmodule

// File: rtl/lsu_outs_fifo.sv
/*
  Outstanding-transaction FIFO
  - Circular buffer of route and user info per accepted command
  - Head is forced to zero while empty
*/
module lsu_outs_fifo #(
  parameter int OUTS_NUM = 2
) (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_push,
  input  lsu_pkg::lsu_outs_t i_push_data,
  input  logic               i_pop,
  output logic               o_full,
  output logic               o_valid,
  output lsu_pkg::lsu_outs_t o_head
);

  localparam int PTR_W = (OUTS_NUM > 1) ? $clog2(OUTS_NUM) : 1;
  localparam int CNT_W = $clog2(OUTS_NUM + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(OUTS_NUM - 1);

  lsu_pkg::lsu_outs_t mem [OUTS_NUM];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   cnt;

  ////////////////////
  // Pointers and fill count

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !i_pop) begin
        cnt <= cnt + 1'b1;
      end else if (!i_push && i_pop) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  ////////////////////
  // Storage

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  assign o_full  = (cnt == CNT_W'(OUTS_NUM));
  assign o_valid = (cnt != '0);

  // Head fields steer response muxes downstream
  assign o_head = o_valid ? mem[rd_ptr] : '0;

endmodule

// File: rtl/lsu_excl_monitor.sv
/*
  Exclusive-access monitor for LR/SC
  - Reservation flag and reserved address
  - Store-conditional pass/fail decision and byte-mask suppression
*/
module lsu_excl_monitor (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_cmd_fire,
  input  lsu_pkg::lsu_cmd_t          i_cmd,
  input  logic                       i_commit_trap,
  input  logic                       i_commit_mret,
  output logic [lsu_pkg::MASK_W-1:0] o_cmd_wmask,
  output logic                       o_scond_true
);

  logic                       excl_flg_r;
  logic [lsu_pkg::ADDR_W-1:0] excl_addr_r;
  logic                       addr_eq;
  logic                       flg_set;
  logic                       flg_clr;
  logic                       scond;

  assign addr_eq = (i_cmd.addr == excl_addr_r);

  // A load-reserved going out arms the reservation
  assign flg_set = i_cmd_fire & i_cmd.read & i_cmd.excl;

  // Any store hitting the reserved word drops it, so do traps and mret
  assign flg_clr = (i_cmd_fire & ~i_cmd.read & addr_eq & excl_flg_r)
                 | i_commit_trap | i_commit_mret;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      excl_flg_r <= 1'b0;
    end else if (flg_set) begin
      excl_flg_r <= 1'b1;
    end else if (flg_clr) begin
      excl_flg_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (flg_set) begin
      excl_addr_r <= i_cmd.addr;
    end
  end

  ////////////////////
  // Store-conditional

  assign scond        = i_cmd.excl & ~i_cmd.read;
  assign o_scond_true = scond & excl_flg_r & addr_eq;

  // Failing SC still goes to the target but writes no bytes
  assign o_cmd_wmask = (scond & ~o_scond_true) ? '0 : i_cmd.wmask;

endmodule

// File: rtl/lsu_pkg.sv
/*
  Shared definitions for the load-store control unit
  - Data, address, tag and byte-mask widths
  - Access-size codes
  - Command, response, user, outstanding-entry and write-back structs
*/
package lsu_pkg;

  parameter int XLEN   = 32;
  parameter int ADDR_W = 32;
  parameter int ITAG_W = 3;
  parameter int MASK_W = XLEN / 8;

  // Access-size codes as carried on the ICB size field
  parameter logic [1:0] SIZE_BYTE = 2'b00;
  parameter logic [1:0] SIZE_HALF = 2'b01;
  parameter logic [1:0] SIZE_WORD = 2'b10;

  // One ICB command beat
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] wmask;
    logic              excl;
    logic [1:0]        size;
  } lsu_cmd_t;

  // One ICB response beat
  typedef struct packed {
    logic            err;
    logic            excl_ok;
    logic [XLEN-1:0] rdata;
  } lsu_rsp_t;

  // Side information that follows a command until its response
  typedef struct packed {
    logic              back2agu;
    logic              usign;
    logic              read;
    logic [1:0]        size;
    logic [ITAG_W-1:0] itag;
    logic [ADDR_W-1:0] addr;
    logic              excl;
  } lsu_usr_t;

  // Outstanding-transaction FIFO entry
  typedef struct packed {
    logic     to_dtcm;
    logic     scond_true;
    lsu_usr_t usr;
  } lsu_outs_t;

  // Write-back payload, including bus-error commit fields
  typedef struct packed {
    logic [XLEN-1:0]   wdat;
    logic [ITAG_W-1:0] itag;
    logic              err;
    logic              buserr;
    logic [ADDR_W-1:0] badaddr;
    logic              ld;
    logic              st;
  } lsu_wbck_t;

endpackage
